//--- source/pdu_consts.svh
`ifndef PDU_CONSTS_SVH
`define PDU_CONSTS_SVH

`define PDU_WORD_W 32
`define PDU_CHAR_W 8

// Inspection bases and legal program window
`define PDU_RF_BASE 32'h0000_1000
`define PDU_DM_BASE 32'h0000_2000
`define PDU_PC_LOW 32'h0000_2ff0
`define PDU_PC_HIGH 32'h0000_3fff

// clk cycles per cpu_clk high phase
`define PDU_CPU_CLK_HALF 50

// Command characters
`define PDU_CH_SEMI ";"
`define PDU_CH_A "a"
`define PDU_CH_B "b"
`define PDU_CH_C "c"
`define PDU_CH_D "d"
`define PDU_CH_E "e"
`define PDU_CH_F "f"
`define PDU_CH_K "k"
`define PDU_CH_N "n"
`define PDU_CH_P "p"
`define PDU_CH_R "r"
`define PDU_CH_S "s"
`define PDU_CH_T "t"
`define PDU_CH_U "u"
`define PDU_CH_0 "0"
`define PDU_CH_1 "1"
`define PDU_CH_2 "2"
`define PDU_CH_9 "9"

`endif

//--- source/pdu_pkg.sv
`include "pdu_consts.svh"

package pdu_pkg;

    typedef logic [`PDU_WORD_W-1:0] word_t;

    typedef logic [`PDU_CHAR_W-1:0] char_t;

    typedef logic [3:0] nibble_t;

    typedef enum logic [2:0] {
        cmd_none,
        cmd_run,
        cmd_step,
        cmd_bp,
        cmd_check,
        cmd_add,
        cmd_sub,
        cmd_cpu_rst
    } cmd_t;

    // Base added to the hex offset of a check command
    typedef enum logic [1:0] {
        base_zero,
        base_rf,
        base_dm
    } base_t;

endpackage

//--- source/pdu_cmd_parser.sv
`include "pdu_consts.svh"

module pdu_cmd_parser (
    input  logic             clk,
    input  logic             rst,
    input  logic             din_vld,
    input  pdu_pkg::char_t   din_data,
    input  logic             running,
    output logic             cmd_vld,
    output pdu_pkg::cmd_t    cmd,
    output pdu_pkg::base_t   base,
    output logic             hex_clear,
    output logic             hex_vld,
    output pdu_pkg::nibble_t hex_digit
);

    typedef enum logic [4:0] {
        st_idle,
        st_s, st_st, st_ste, st_step, st_su, st_sub,
        st_r, st_ru, st_run, st_rs, st_rst,
        st_a, st_ad, st_add,
        st_b, st_bp_hex,
        st_c, st_ck, st_ck_hex
    } state_t;

    state_t           state;
    state_t           state_nxt;
    logic             take;
    logic             hex_mode;
    logic             fire;
    logic             clear_nxt;
    logic             digit_vld_nxt;
    pdu_pkg::cmd_t    cmd_nxt;
    pdu_pkg::base_t   base_nxt;
    pdu_pkg::nibble_t digit_nxt;

    function automatic logic is_hex(input pdu_pkg::char_t c);
        return (c >= `PDU_CH_0 && c <= `PDU_CH_9) || (c >= `PDU_CH_A && c <= `PDU_CH_F);
    endfunction

    // Low nibble of '0'..'9' is the value, 'a'..'f' need 9 more
    function automatic pdu_pkg::nibble_t hex_val(input pdu_pkg::char_t c);
        return (c <= `PDU_CH_9) ? c[3:0] : c[3:0] + 4'd9;
    endfunction

    // Command ended by ';' in each keyword's last state
    function automatic pdu_pkg::cmd_t word_cmd(input state_t s);
        case (s)
            st_step: return pdu_pkg::cmd_step;
            st_sub:  return pdu_pkg::cmd_sub;
            st_run:  return pdu_pkg::cmd_run;
            st_rst:  return pdu_pkg::cmd_cpu_rst;
            st_add:  return pdu_pkg::cmd_add;
            default: return pdu_pkg::cmd_none;
        endcase
    endfunction

    // Input is dropped while the CPU runs
    assign take = din_vld && !running;

    always_comb begin
        state_nxt     = state;
        fire          = 1'b0;
        clear_nxt     = 1'b0;
        digit_vld_nxt = 1'b0;
        cmd_nxt       = cmd;
        base_nxt      = base;
        digit_nxt     = hex_digit;
        hex_mode      = 1'b0;
        if (take) begin
            // A wrong letter lands back in idle
            state_nxt = st_idle;
            case (state)
                st_idle: begin
                    case (din_data)
                        `PDU_CH_S: state_nxt = st_s;
                        `PDU_CH_R: state_nxt = st_r;
                        `PDU_CH_A: state_nxt = st_a;
                        `PDU_CH_B: state_nxt = st_b;
                        `PDU_CH_C: state_nxt = st_c;
                        default:   state_nxt = st_idle;
                    endcase
                end
                st_s: begin
                    case (din_data)
                        `PDU_CH_T: state_nxt = st_st;
                        `PDU_CH_U: state_nxt = st_su;
                        default:   state_nxt = st_idle;
                    endcase
                end
                st_r: begin
                    case (din_data)
                        `PDU_CH_U: state_nxt = st_ru;
                        `PDU_CH_S: state_nxt = st_rs;
                        default:   state_nxt = st_idle;
                    endcase
                end
                st_st:  state_nxt = (din_data == `PDU_CH_E) ? st_ste : st_idle;
                st_ste: state_nxt = (din_data == `PDU_CH_P) ? st_step : st_idle;
                st_su:  state_nxt = (din_data == `PDU_CH_B) ? st_sub : st_idle;
                st_ru:  state_nxt = (din_data == `PDU_CH_N) ? st_run : st_idle;
                st_rs:  state_nxt = (din_data == `PDU_CH_T) ? st_rst : st_idle;
                st_a:   state_nxt = (din_data == `PDU_CH_D) ? st_ad : st_idle;
                st_ad:  state_nxt = (din_data == `PDU_CH_D) ? st_add : st_idle;
                st_c:   state_nxt = (din_data == `PDU_CH_K) ? st_ck : st_idle;
                st_step, st_sub, st_run, st_rst, st_add: begin
                    if (din_data == `PDU_CH_SEMI) begin
                        fire    = 1'b1;
                        cmd_nxt = word_cmd(state);
                    end
                end
                st_b: begin
                    if (din_data == `PDU_CH_P) begin
                        state_nxt = st_bp_hex;
                        clear_nxt = 1'b1;
                        cmd_nxt   = pdu_pkg::cmd_bp;
                    end
                end
                // Character after "ck" picks the base or is already part of the entry
                st_ck: begin
                    state_nxt = st_ck_hex;
                    clear_nxt = 1'b1;
                    cmd_nxt   = pdu_pkg::cmd_check;
                    case (din_data)
                        `PDU_CH_1: base_nxt = pdu_pkg::base_rf;
                        `PDU_CH_2: base_nxt = pdu_pkg::base_dm;
                        default: begin
                            base_nxt = pdu_pkg::base_zero;
                            hex_mode = 1'b1;
                        end
                    endcase
                end
                st_bp_hex, st_ck_hex: begin
                    state_nxt = state;
                    hex_mode  = 1'b1;
                end
                default: state_nxt = st_idle;
            endcase
            if (hex_mode) begin
                if (din_data == `PDU_CH_SEMI) begin
                    state_nxt = st_idle;
                    fire      = 1'b1;
                end else if (is_hex(din_data)) begin
                    digit_vld_nxt = 1'b1;
                    digit_nxt     = hex_val(din_data);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_idle;
            cmd_vld   <= 1'b0;
            hex_clear <= 1'b0;
            hex_vld   <= 1'b0;
        end else begin
            state     <= state_nxt;
            cmd_vld   <= fire;
            hex_clear <= clear_nxt;
            hex_vld   <= digit_vld_nxt;
        end
    end

    // cmd also names the entry kind while hex_clear is high
    always_ff @(posedge clk) begin
        cmd       <= cmd_nxt;
        base      <= base_nxt;
        hex_digit <= digit_nxt;
    end

endmodule

//--- source/pdu_debug_regs.sv
`include "pdu_consts.svh"

module pdu_debug_regs (
    input  logic             clk,
    input  logic             rst,
    input  logic             cmd_vld,
    input  pdu_pkg::cmd_t    cmd,
    input  pdu_pkg::base_t   base,
    input  logic             hex_clear,
    input  logic             hex_vld,
    input  pdu_pkg::nibble_t hex_digit,
    input  pdu_pkg::word_t   next_pc,
    output pdu_pkg::word_t   check_addr,
    output pdu_pkg::word_t   bp_pc
);

    logic           bp_entry;
    logic           bp_entry_now;
    pdu_pkg::base_t base_sel;
    pdu_pkg::base_t base_now;
    pdu_pkg::word_t offset;
    pdu_pkg::word_t offset_now;
    pdu_pkg::word_t base_addr;

    // A check entry can start together with its first digit or its ';'
    always_comb begin
        bp_entry_now = hex_clear ? (cmd == pdu_pkg::cmd_bp) : bp_entry;
        base_now     = hex_clear ? base : base_sel;
        offset_now   = hex_clear ? '0 : offset;
        case (base_now)
            pdu_pkg::base_rf: base_addr = `PDU_RF_BASE;
            pdu_pkg::base_dm: base_addr = `PDU_DM_BASE;
            default:          base_addr = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bp_entry <= 1'b0;
        end else if (hex_clear) begin
            bp_entry <= bp_entry_now;
        end
    end

    // Offset accumulator of the check entry
    always_ff @(posedge clk) begin
        base_sel <= base_now;
        if (hex_vld && !bp_entry_now) begin
            offset <= {offset_now[`PDU_WORD_W-5:0], hex_digit};
        end else begin
            offset <= offset_now;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            check_addr <= '0;
            bp_pc      <= '0;
        end else begin
            if (cmd_vld) begin
                case (cmd)
                    pdu_pkg::cmd_check: check_addr <= base_addr + offset_now;
                    pdu_pkg::cmd_add:   check_addr <= check_addr + pdu_pkg::word_t'(1);
                    pdu_pkg::cmd_sub:   check_addr <= check_addr - pdu_pkg::word_t'(1);
                    pdu_pkg::cmd_step:  bp_pc <= next_pc;
                    default: ;
                endcase
            end
            // Breakpoint digits go straight into bp_pc
            if (hex_clear && bp_entry_now) begin
                bp_pc <= '0;
            end else if (hex_vld && bp_entry_now) begin
                bp_pc <= {bp_pc[`PDU_WORD_W-5:0], hex_digit};
            end
        end
    end

endmodule

//--- source/pdu_run_ctrl.sv
`include "pdu_consts.svh"

module pdu_run_ctrl (
    input  logic           clk,
    input  logic           rst,
    input  logic           cmd_vld,
    input  pdu_pkg::cmd_t  cmd,
    input  pdu_pkg::word_t current_pc,
    input  pdu_pkg::word_t bp_pc,
    input  logic           ebreak,
    output logic           running,
    output logic           cpu_clk,
    output logic           cpu_rst
);

    localparam int cnt_last = 2 * `PDU_CPU_CLK_HALF;
    localparam int cnt_w = $clog2(cnt_last + 1);

    logic [cnt_w-1:0] clk_cnt;
    logic             start;
    logic             stop;

    assign start = cmd_vld && (cmd == pdu_pkg::cmd_run || cmd == pdu_pkg::cmd_step);

    assign stop = ebreak || (current_pc == bp_pc) ||
                  (current_pc < `PDU_PC_LOW) || (current_pc > `PDU_PC_HIGH);

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            cpu_rst <= 1'b0;
        end else begin
            cpu_rst <= cmd_vld && (cmd == pdu_pkg::cmd_cpu_rst);
            if (start) begin
                running <= 1'b1;
            end else if (running && stop) begin
                running <= 1'b0;
            end
        end
    end

    // High for cnt 0..HALF-1, low up to cnt_last, then the period is over
    always_ff @(posedge clk) begin
        if (rst) begin
            clk_cnt <= '0;
            cpu_clk <= 1'b0;
        end else if (running || clk_cnt != '0) begin
            if (clk_cnt == cnt_w'(cnt_last)) begin
                clk_cnt <= '0;
                cpu_clk <= 1'b0;
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
                cpu_clk <= (clk_cnt < cnt_w'(`PDU_CPU_CLK_HALF));
            end
        end
    end

endmodule

//--- source/pdu_ctrl.sv
module pdu_ctrl (
    input  logic           clk,
    input  logic           rst,
    input  logic           din_vld,
    input  pdu_pkg::char_t din_data,
    input  pdu_pkg::word_t current_pc,
    input  pdu_pkg::word_t next_pc,
    input  logic           ebreak,
    output pdu_pkg::word_t check_addr,
    output logic           cpu_clk,
    output logic           cpu_rst,
    output logic           running
);

    logic             cmd_vld;
    pdu_pkg::cmd_t    cmd;
    pdu_pkg::base_t   base;
    logic             hex_clear;
    logic             hex_vld;
    pdu_pkg::nibble_t hex_digit;
    pdu_pkg::word_t   bp_pc;

    pdu_cmd_parser u_parser (
        .clk       (clk),
        .rst       (rst),
        .din_vld   (din_vld),
        .din_data  (din_data),
        .running   (running),
        .cmd_vld   (cmd_vld),
        .cmd       (cmd),
        .base      (base),
        .hex_clear (hex_clear),
        .hex_vld   (hex_vld),
        .hex_digit (hex_digit)
    );

    pdu_debug_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .cmd_vld    (cmd_vld),
        .cmd        (cmd),
        .base       (base),
        .hex_clear  (hex_clear),
        .hex_vld    (hex_vld),
        .hex_digit  (hex_digit),
        .next_pc    (next_pc),
        .check_addr (check_addr),
        .bp_pc      (bp_pc)
    );

    pdu_run_ctrl u_run (
        .clk        (clk),
        .rst        (rst),
        .cmd_vld    (cmd_vld),
        .cmd        (cmd),
        .current_pc (current_pc),
        .bp_pc      (bp_pc),
        .ebreak     (ebreak),
        .running    (running),
        .cpu_clk    (cpu_clk),
        .cpu_rst    (cpu_rst)
    );

endmodule

//--- verification/pdu_ctrl_properties.sv
module pdu_ctrl_properties (
    input logic clk,
    input logic rst,
    input logic running,
    input logic cpu_clk,
    input logic cpu_rst,
    input logic ebreak
);

    timeunit 1ns;
    timeprecision 1ps;

    // CPU reset is a single-cycle pulse
    cpu_rst_one_cycle: assert property (
        @(posedge clk) disable iff (rst) cpu_rst |=> !cpu_rst
    ) else $error("cpu_rst stayed high for two cycles");

    // A new cpu_clk period only starts while running
    cpu_clk_idle: assert property (
        @(posedge clk) disable iff (rst) $rose(cpu_clk) |-> $past(running)
    ) else $error("cpu_clk started a period while the controller was stopped");

    ebreak_stops_run: assert property (
        @(posedge clk) disable iff (rst) (running && ebreak) |=> !running
    ) else $error("running did not fall after ebreak");

endmodule

//--- verification/pdu_ctrl_tb_tasks.svh
`ifndef PDU_CTRL_TB_TASKS_SVH
`define PDU_CTRL_TB_TASKS_SVH

task automatic fail_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped at the first error");
endtask

task automatic check_word(input string name, input pdu_pkg::word_t got,
                          input pdu_pkg::word_t exp);
    if (got !== exp) begin
        fail_run($sformatf("error %s: got 0x%h, expected 0x%h", name, got, exp));
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        fail_run($sformatf("error %s: got 0x%h, expected 0x%h", name, got, exp));
    end
endtask

task automatic next_cycle();
    @(posedge clk);
    #2;
endtask

// One character per cycle with ';' sampled at the last edge
task automatic send_cmd(input string text);
    for (int i = 0; i < text.len(); i++) begin
        @(posedge clk);
        #2;
        din_vld  = 1'b1;
        din_data = text[i];
    end
    next_cycle();
    din_vld  = 1'b0;
    din_data = '0;
endtask

task automatic wait_running(input logic level, input int limit);
    int n;
    n = 0;
    while (running !== level && n < limit) begin
        next_cycle();
        n++;
    end
    if (running !== level) begin
        fail_run($sformatf("timeout waiting for running to become %0b", level));
    end
endtask

// Low phase lasts at most HALF+1 cycles, so a longer low stretch means idle
task automatic wait_cpu_clk_idle();
    int n;
    int low_cnt;
    n = 0;
    low_cnt = 0;
    while (low_cnt < `PDU_CPU_CLK_HALF + 2 && n < 4 * `PDU_CPU_CLK_HALF + 8) begin
        next_cycle();
        low_cnt = (cpu_clk || running) ? 0 : low_cnt + 1;
        n++;
    end
    if (low_cnt < `PDU_CPU_CLK_HALF + 2) begin
        fail_run("cpu_clk did not settle low after the run ended");
    end
endtask

function automatic string hex4(input logic [15:0] v);
    return $sformatf("%h", v);
endfunction

`endif

//--- verification/pdu_ctrl_tb.sv
`include "pdu_consts.svh"

module pdu_ctrl_tb;

    timeunit 1ns;
    timeprecision 1ps;

    logic           clk;
    logic           rst;
    logic           din_vld;
    pdu_pkg::char_t din_data;
    pdu_pkg::word_t current_pc;
    pdu_pkg::word_t next_pc;
    logic           ebreak;
    pdu_pkg::word_t check_addr;
    logic           cpu_clk;
    logic           cpu_rst;
    logic           running;

    pdu_pkg::word_t cpu_pc;
    logic           cpu_clk_q;
    logic           ebreak_en;
    pdu_pkg::word_t ebreak_pc;
    pdu_pkg::word_t exp_addr;
    int             seed;

    pdu_ctrl uut (
        .clk        (clk),
        .rst        (rst),
        .din_vld    (din_vld),
        .din_data   (din_data),
        .current_pc (current_pc),
        .next_pc    (next_pc),
        .ebreak     (ebreak),
        .check_addr (check_addr),
        .cpu_clk    (cpu_clk),
        .cpu_rst    (cpu_rst),
        .running    (running)
    );

    bind pdu_ctrl pdu_ctrl_properties u_props (
        .clk     (clk),
        .rst     (rst),
        .running (running),
        .cpu_clk (cpu_clk),
        .cpu_rst (cpu_rst),
        .ebreak  (ebreak)
    );

    `include "pdu_ctrl_tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // CPU model steps one instruction per cpu_clk rise
    assign current_pc = cpu_pc;
    assign next_pc    = cpu_pc + 32'd4;
    assign ebreak     = ebreak_en && (cpu_pc == ebreak_pc);

    always @(posedge clk) begin
        #2;
        if (rst || cpu_rst) begin
            cpu_pc <= 32'h0000_3000;
        end else if (cpu_clk && !cpu_clk_q) begin
            cpu_pc <= cpu_pc + 32'd4;
        end
        cpu_clk_q <= cpu_clk;
    end

    // Old value during the cmd_vld cycle and the new value one cycle later
    task automatic expect_addr_update(input pdu_pkg::word_t new_addr);
        check_word("check_addr", check_addr, exp_addr);
        next_cycle();
        check_word("check_addr", check_addr, new_addr);
        exp_addr = new_addr;
    endtask

    task automatic enter_check(input string prefix, input pdu_pkg::word_t base_addr);
        logic [15:0] offset;
        offset = 16'($random(seed));
        send_cmd({prefix, hex4(offset), ";"});
        expect_addr_update(base_addr + {16'h0, offset});
    endtask

    task automatic test_check_entry();
        // Leading 0 keeps the first digit from selecting a base
        enter_check("ck0", 32'h0);
        enter_check("ck1", `PDU_RF_BASE);
        enter_check("ck2", `PDU_DM_BASE);
        enter_check("ck0", 32'h0);
    endtask

    task automatic test_add_sub();
        send_cmd("add;");
        expect_addr_update(exp_addr + 32'd1);
        send_cmd("sub;");
        expect_addr_update(exp_addr - 32'd1);
        send_cmd("sub;");
        expect_addr_update(exp_addr - 32'd1);
        send_cmd("adx;");
        expect_addr_update(exp_addr);
        send_cmd("sbu;");
        expect_addr_update(exp_addr);
    endtask

    task automatic test_breakpoint_run();
        send_cmd("bp3010;");
        send_cmd("run;");
        wait_running(1'b1, 4);
        wait_running(1'b0, 8 * (2 * `PDU_CPU_CLK_HALF + 1));
        check_word("current_pc", current_pc, 32'h0000_3010);
        wait_cpu_clk_idle();
        check_word("current_pc", current_pc, 32'h0000_3010);
    endtask

    task automatic test_step();
        pdu_pkg::word_t pc_before;
        pc_before = current_pc;
        send_cmd("step;");
        wait_running(1'b1, 4);
        wait_running(1'b0, 3 * (2 * `PDU_CPU_CLK_HALF + 1));
        check_word("current_pc", current_pc, pc_before + 32'd4);
        wait_cpu_clk_idle();
        check_word("current_pc", current_pc, pc_before + 32'd4);
    endtask

    task automatic pulse_cpu_reset();
        int n;
        send_cmd("rst;");
        n = 0;
        while (!cpu_rst && n < 4) begin
            next_cycle();
            n++;
        end
        if (!cpu_rst) begin
            fail_run("timeout waiting for the cpu_rst pulse");
        end
        next_cycle();
        check_bit("cpu_rst", cpu_rst, 1'b0);
        check_word("current_pc", current_pc, 32'h0000_3000);
    endtask

    task automatic test_ebreak_and_reset();
        pulse_cpu_reset();
        send_cmd("bp3ff0;");
        ebreak_pc = 32'h0000_3008;
        ebreak_en = 1'b1;
        send_cmd("run;");
        wait_running(1'b1, 4);
        wait_running(1'b0, 6 * (2 * `PDU_CPU_CLK_HALF + 1));
        check_word("current_pc", current_pc, 32'h0000_3008);
        wait_cpu_clk_idle();
        ebreak_en = 1'b0;
        pulse_cpu_reset();
    endtask

    initial begin
        seed      = 87;
        rst       = 1'b1;
        din_vld   = 1'b0;
        din_data  = '0;
        cpu_pc    = 32'h0000_3000;
        cpu_clk_q = 1'b0;
        ebreak_en = 1'b0;
        ebreak_pc = '0;
        exp_addr  = '0;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        check_word("check_addr", check_addr, 32'h0);
        check_bit("running", running, 1'b0);
        check_bit("cpu_rst", cpu_rst, 1'b0);
        check_bit("cpu_clk", cpu_clk, 1'b0);
        test_check_entry();
        test_add_sub();
        test_breakpoint_run();
        test_step();
        test_ebreak_and_reset();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- pdu_ctrl.f
+incdir+source
+incdir+verification
source/pdu_pkg.sv
source/pdu_cmd_parser.sv
source/pdu_debug_regs.sv
source/pdu_run_ctrl.sv
source/pdu_ctrl.sv
verification/pdu_ctrl_properties.sv
verification/pdu_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench; the exit status reports pass or fail
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module pdu_ctrl_tb -f pdu_ctrl.f -o pdu_ctrl_sim

./obj_dir/pdu_ctrl_sim
